// ==== design/wb_bus_pkg.sv ====
// Bus package with widths, memory size, atomic opcodes and the request and response types.
package wb_bus_pkg;

	// Bus widths.
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;

	// SRAM depth in words.
	localparam int MEM_WORDS = 256;
	localparam int IDX_W     = $clog2(MEM_WORDS); // Word index is adr[IDX_W+1:2].

	// Atomic opcodes carried in the Wishbone cycle tag.
	typedef enum logic [3:0] {
		NONE = 4'd0, // Plain read or write.
		SWAP = 4'd1,
		ADD  = 4'd2,
		XOR  = 4'd3,
		AND  = 4'd4,
		OR   = 4'd5,
		MIN  = 4'd6, // Signed.
		MAX  = 4'd7, // Signed.
		MINU = 4'd8,
		MAXU = 4'd9
	} amo_op_t;

	// Data request as presented by the core.
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [SEL_W-1:0]  wstb;
		logic              write;
		amo_op_t           amo;
	} core_dreq_t;

	// Initiator to target.
	typedef struct packed {
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat_w;
		logic [SEL_W-1:0]  sel;
		logic              we;
		logic              cyc;
		logic              stb;
		amo_op_t           tgc;
	} wb_req_t;

	// Target to initiator.
	typedef struct packed {
		logic [DATA_W-1:0] dat_r;
		logic              ack;
	} wb_rsp_t;

endpackage

// ==== design/sram_bank.sv ====
`timescale 1ns/10ps
// Word-wide synchronous SRAM with byte write enables and a registered read.
module sram_bank (
	input  logic                          clock,
	input  logic                          en,
	input  logic                          we,
	input  logic [wb_bus_pkg::SEL_W-1:0]  be,
	input  logic [wb_bus_pkg::IDX_W-1:0]  index,
	input  logic [wb_bus_pkg::DATA_W-1:0] wdata,
	output logic [wb_bus_pkg::DATA_W-1:0] rdata
);

	logic [wb_bus_pkg::DATA_W-1:0] mem [wb_bus_pkg::MEM_WORDS];

	// Byte lanes written under their enables.
	always_ff @(posedge clock) begin
		if (en && we) begin
			for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
				if (be[b]) begin
					mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// Read returns the word as it was before this edge.
	always_ff @(posedge clock) begin
		if (en) begin
			rdata <= mem[index];
		end
	end

endmodule

// ==== design/wb_amo_unit.sv ====
`timescale 1ns/10ps
// Wishbone target that runs reads, strobed writes and atomic read-modify-write on the SRAM.
module wb_amo_unit (
	input  logic                              clock,
	input  logic                              reset,
	input  wb_bus_pkg::wb_req_t               wb_req,
	output wb_bus_pkg::wb_rsp_t               wb_rsp,
	// SRAM side.
	output logic                              mem_en,
	output logic                              mem_we,
	output logic [wb_bus_pkg::SEL_W-1:0]      mem_be,
	output logic [wb_bus_pkg::IDX_W-1:0]      mem_index,
	output logic [wb_bus_pkg::DATA_W-1:0]     mem_wdata,
	input  logic [wb_bus_pkg::DATA_W-1:0]     mem_rdata
);

	typedef enum logic [2:0] {
		IDLE,
		READ,   // Read data arrives from the SRAM.
		MODIFY, // Old word arrives, result is computed.
		WRITE,  // Result goes back to memory.
		DONE    // Wait for the initiator to drop cyc.
	} state_t;

	state_t state;

	logic                          start;
	logic                          is_amo;
	logic                          ack_q;
	logic [wb_bus_pkg::DATA_W-1:0] dat_r_q;
	logic [wb_bus_pkg::DATA_W-1:0] result_q;

	function automatic logic [wb_bus_pkg::DATA_W-1:0] amo_calc(
		input wb_bus_pkg::amo_op_t           op,
		input logic [wb_bus_pkg::DATA_W-1:0] old,
		input logic [wb_bus_pkg::DATA_W-1:0] opd
	);
		case (op)
			wb_bus_pkg::SWAP: return opd;
			wb_bus_pkg::ADD:  return old + opd; // Wraps.
			wb_bus_pkg::XOR:  return old ^ opd;
			wb_bus_pkg::AND:  return old & opd;
			wb_bus_pkg::OR:   return old | opd;
			wb_bus_pkg::MIN:  return ($signed(old) < $signed(opd)) ? old : opd;
			wb_bus_pkg::MAX:  return ($signed(old) > $signed(opd)) ? old : opd;
			wb_bus_pkg::MINU: return (old < opd) ? old : opd;
			wb_bus_pkg::MAXU: return (old > opd) ? old : opd;
			default:          return old;
		endcase
	endfunction

	assign start  = (state == IDLE) && wb_req.cyc && wb_req.stb;
	assign is_amo = (wb_req.tgc != wb_bus_pkg::NONE);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			ack_q <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						if (is_amo) begin
							state <= MODIFY;
						end else if (wb_req.we) begin
							state <= DONE; // Write lands this edge.
							ack_q <= 1'b1;
						end else begin
							state <= READ;
						end
					end
				end
				READ: begin
					state <= DONE;
					ack_q <= 1'b1;
				end
				MODIFY: state <= WRITE;
				WRITE: begin
					state <= DONE;
					ack_q <= 1'b1;
				end
				default: begin
					if (!wb_req.cyc) state <= IDLE;
				end
			endcase
		end
	end

	// Read data holds the old word for atomics.
	always_ff @(posedge clock) begin
		if ((state == READ) || (state == MODIFY)) begin
			dat_r_q <= mem_rdata;
		end
		if (state == MODIFY) begin
			result_q <= amo_calc(wb_req.tgc, mem_rdata, wb_req.dat_w);
		end
	end

	assign mem_en    = start || (state == WRITE);
	assign mem_we    = (start && !is_amo && wb_req.we) || (state == WRITE);
	assign mem_be    = (state == WRITE) ? '1 : wb_req.sel; // Atomics write the full word.
	assign mem_index = wb_req.adr[wb_bus_pkg::IDX_W+1:2];
	assign mem_wdata = (state == WRITE) ? result_q : wb_req.dat_w;

	assign wb_rsp.dat_r = dat_r_q;
	assign wb_rsp.ack   = ack_q;

endmodule

// ==== design/rv_bus_bridge.sv ====
`timescale 1ns/10ps
// Bus bridge that merges the instruction and data ports onto one Wishbone initiator.
module rv_bus_bridge (
	input  logic                              clock,
	input  logic                              reset,
	// Instruction fetch port.
	input  logic                              ivalid,
	input  logic [wb_bus_pkg::ADDR_W-1:0]     iaddr,
	output logic                              iready,
	output logic [wb_bus_pkg::DATA_W-1:0]     idata,
	// Data port.
	input  logic                              dvalid,
	input  wb_bus_pkg::core_dreq_t            dreq,
	output logic                              dready,
	output logic [wb_bus_pkg::DATA_W-1:0]     drdata,
	// Wishbone initiator.
	output wb_bus_pkg::wb_req_t               wb_req,
	input  wb_bus_pkg::wb_rsp_t               wb_rsp
);

	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		DATA  = 2'b01,
		FETCH = 2'b10,
		TURN  = 2'b11 // One dead cycle after each bus cycle.
	} state_t;

	state_t state;

	logic                          cyc_q;
	logic                          iready_q;
	logic                          dready_q;
	logic [wb_bus_pkg::ADDR_W-1:0] adr_q;
	logic [wb_bus_pkg::DATA_W-1:0] dat_w_q;
	logic [wb_bus_pkg::SEL_W-1:0]  sel_q;
	logic                          we_q;
	wb_bus_pkg::amo_op_t           tgc_q;
	logic [wb_bus_pkg::DATA_W-1:0] rdata_q;

	logic start_d;
	logic start_i;
	logic done;

	// Data port wins in IDLE.
	assign start_d = (state == IDLE) && dvalid;
	assign start_i = (state == IDLE) && !dvalid && ivalid;
	assign done    = ((state == DATA) || (state == FETCH)) && wb_rsp.ack;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state    <= IDLE;
			cyc_q    <= 1'b0;
			iready_q <= 1'b0;
			dready_q <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start_d) begin
						state <= DATA;
						cyc_q <= 1'b1;
					end else if (start_i) begin
						state <= FETCH;
						cyc_q <= 1'b1;
					end
				end
				DATA, FETCH: begin
					if (done) begin
						state    <= TURN;
						cyc_q    <= 1'b0;
						dready_q <= (state == DATA);
						iready_q <= (state == FETCH);
					end
				end
				default: begin
					state    <= IDLE; // Ready pulse ends here.
					iready_q <= 1'b0;
					dready_q <= 1'b0;
				end
			endcase
		end
	end

	// Request payload and the shared read data register.
	always_ff @(posedge clock) begin
		if (start_d) begin
			adr_q   <= dreq.addr;
			dat_w_q <= dreq.wdata;
			sel_q   <= dreq.wstb;
			we_q    <= dreq.write;
			tgc_q   <= dreq.amo;
		end else if (start_i) begin
			adr_q   <= iaddr;
			dat_w_q <= '0;
			sel_q   <= '0;        // Fetches carry no strobes.
			we_q    <= 1'b0;
			tgc_q   <= wb_bus_pkg::NONE;
		end
		if (done) begin
			rdata_q <= wb_rsp.dat_r;
		end
	end

	always_comb begin
		wb_req.adr   = adr_q;
		wb_req.dat_w = dat_w_q;
		wb_req.sel   = sel_q;
		wb_req.we    = we_q;
		wb_req.cyc   = cyc_q;
		wb_req.stb   = cyc_q; // Strobe follows cycle.
		wb_req.tgc   = tgc_q;
	end

	assign iready = iready_q;
	assign dready = dready_q;
	assign idata  = rdata_q;
	assign drdata = rdata_q;

endmodule

// ==== design/wb_subsystem_top.sv ====
`timescale 1ns/10ps
// Memory subsystem top with the bus bridge, the atomic unit and the SRAM.
module wb_subsystem_top (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              ivalid,
	input  logic [wb_bus_pkg::ADDR_W-1:0]     iaddr,
	output logic                              iready,
	output logic [wb_bus_pkg::DATA_W-1:0]     idata,
	input  logic                              dvalid,
	input  wb_bus_pkg::core_dreq_t            dreq,
	output logic                              dready,
	output logic [wb_bus_pkg::DATA_W-1:0]     drdata
);

	wb_bus_pkg::wb_req_t           wb_req;
	wb_bus_pkg::wb_rsp_t           wb_rsp;
	logic                          mem_en;
	logic                          mem_we;
	logic [wb_bus_pkg::SEL_W-1:0]  mem_be;
	logic [wb_bus_pkg::IDX_W-1:0]  mem_index;
	logic [wb_bus_pkg::DATA_W-1:0] mem_wdata;
	logic [wb_bus_pkg::DATA_W-1:0] mem_rdata;

	rv_bus_bridge u_bridge (
		.clock  (clock),
		.reset  (reset),
		.ivalid (ivalid),
		.iaddr  (iaddr),
		.iready (iready),
		.idata  (idata),
		.dvalid (dvalid),
		.dreq   (dreq),
		.dready (dready),
		.drdata (drdata),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	wb_amo_unit u_amo (
		.clock     (clock),
		.reset     (reset),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_be    (mem_be),
		.mem_index (mem_index),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	sram_bank u_sram (
		.clock (clock),
		.en    (mem_en),
		.we    (mem_we),
		.be    (mem_be),
		.index (mem_index),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/10ps
// Testbench clock and reset source with a 100 ns period and a 10 cycle reset.
module tb_clock_gen (
	output logic clock,
	output logic reset
);

	localparam int HALF_NS      = 50;
	localparam int RESET_CYCLES = 10;

	initial begin
		clock = 1'b0;
		forever #HALF_NS clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0; // Released on a rising edge.
	end

endmodule

// ==== dv/rv_bus_bridge_props.sv ====
`timescale 1ns/10ps
// Bridge assertions on handshake shape and Wishbone request stability.
module rv_bus_bridge_props (
	input logic                clock,
	input logic                reset,
	input logic                iready,
	input logic                dready,
	input wb_bus_pkg::wb_req_t wb_req,
	input wb_bus_pkg::wb_rsp_t wb_rsp
);

	a_cyc_stb: assert property (@(posedge clock) disable iff (reset)
		wb_req.cyc == wb_req.stb)
		else $error("cyc and stb differ");

	a_ready_excl: assert property (@(posedge clock) disable iff (reset)
		!(iready && dready))
		else $error("iready and dready high together");

	// A ready never lasts into a second cycle.
	a_ready_pulse: assert property (@(posedge clock) disable iff (reset)
		(iready || dready) |=> !(iready || dready))
		else $error("ready held longer than one cycle");

	a_req_stable: assert property (@(posedge clock) disable iff (reset)
		(wb_req.cyc && !wb_rsp.ack) |=> $stable(wb_req))
		else $error("Wishbone request changed before ack");

endmodule

bind rv_bus_bridge rv_bus_bridge_props u_props (
	.clock  (clock),
	.reset  (reset),
	.iready (iready),
	.dready (dready),
	.wb_req (wb_req),
	.wb_rsp (wb_rsp)
);

// ==== dv/tb_checker.sv ====
`timescale 1ns/10ps
// Checker with a mirror memory that predicts each ready's data and checks port ordering.
module tb_checker (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              ivalid,
	input  logic [wb_bus_pkg::ADDR_W-1:0]     iaddr,
	input  logic                              iready,
	input  logic [wb_bus_pkg::DATA_W-1:0]     idata,
	input  logic                              dvalid,
	input  wb_bus_pkg::core_dreq_t            dreq,
	input  logic                              dready,
	input  logic [wb_bus_pkg::DATA_W-1:0]     drdata,
	input  int                                test_id,
	input  logic                              test_end,
	output int                                errors,
	output int                                checks
);

	logic [wb_bus_pkg::DATA_W-1:0] mirror [wb_bus_pkg::MEM_WORDS]; // Starts unknown.
	logic [wb_bus_pkg::IDX_W-1:0]  idx;
	int     err_cnt = 0;
	int     chk_cnt = 0;
	int     test_errs = 0;
	int     test_checks = 0;
	longint cycle = 0;
	longint d_start = 0;
	longint i_start = 0;
	bit     d_pend = 1'b0;
	bit     i_pend = 1'b0;

	assign errors = err_cnt;
	assign checks = chk_cnt;

	function automatic string test_name(input int id);
		case (id)
			0:       return "reset_quiet";
			1:       return "write_fetch";
			2:       return "strobe_merge";
			3:       return "amo_ops";
			4:       return "arbitration";
			default: return "random_mix";
		endcase
	endfunction

	// Signed compares by flipping the sign bit.
	function automatic logic [31:0] amo_ref(
		input wb_bus_pkg::amo_op_t op,
		input logic [31:0]         old,
		input logic [31:0]         opd
	);
		logic [31:0] old_s;
		logic [31:0] opd_s;
		old_s = old ^ 32'h8000_0000;
		opd_s = opd ^ 32'h8000_0000;
		case (op)
			wb_bus_pkg::SWAP: return opd;
			wb_bus_pkg::ADD:  return old + opd;
			wb_bus_pkg::XOR:  return old ^ opd;
			wb_bus_pkg::AND:  return old & opd;
			wb_bus_pkg::OR:   return old | opd;
			wb_bus_pkg::MIN:  return (old_s <= opd_s) ? old : opd;
			wb_bus_pkg::MAX:  return (old_s >= opd_s) ? old : opd;
			wb_bus_pkg::MINU: return (old <= opd) ? old : opd;
			wb_bus_pkg::MAXU: return (old >= opd) ? old : opd;
			default:          return old;
		endcase
	endfunction

	// New memory word after a data request.
	function automatic logic [31:0] next_word(
		input wb_bus_pkg::core_dreq_t r,
		input logic [31:0]            old
	);
		logic [31:0] mask;
		mask = '0;
		for (int b = 0; b < wb_bus_pkg::SEL_W; b++) begin
			if (r.wstb[b]) mask[8*b +: 8] = 8'hff;
		end
		if (r.amo != wb_bus_pkg::NONE) return amo_ref(r.amo, old, r.wdata);
		if (r.write) return (old & ~mask) | (r.wdata & mask);
		return old;
	endfunction

	task automatic compare(input string port, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		test_checks++;
		if (act !== exp) begin
			err_cnt++;
			test_errs++;
			$display("[ERROR] %s: %s expected %h, actual %h",
				test_name(test_id), port, exp, act);
		end
	endtask

	task automatic report(input string what);
		err_cnt++;
		test_errs++;
		$display("%s: %s", test_name(test_id), what);
	endtask

	always @(posedge clock) begin
		cycle++;
		if (reset) begin
			// Readies may still be unknown on the very first edge of reset.
			if (cycle > 1 && (iready !== 1'b0 || dready !== 1'b0)) begin
				report("a ready was not held low while reset was asserted");
			end
			d_pend = 1'b0;
			i_pend = 1'b0;
		end else begin
			if (dready) begin
				if (!d_pend) begin
					report("dready pulsed with no outstanding data request");
				end else begin
					idx = dreq.addr[wb_bus_pkg::IDX_W+1:2];
					if (!dreq.write || dreq.amo != wb_bus_pkg::NONE) begin
						compare("drdata", mirror[idx], drdata); // Old word for atomics.
					end
					mirror[idx] = next_word(dreq, mirror[idx]);
				end
				d_pend = 1'b0;
			end else if (dvalid && !d_pend) begin
				d_pend  = 1'b1;
				d_start = cycle;
			end
			if (iready) begin
				if (!i_pend) begin
					report("iready pulsed with no outstanding fetch");
				end else begin
					if (d_pend && d_start <= i_start) begin
						report("fetch was served ahead of an earlier data request");
					end
					compare("idata", mirror[iaddr[wb_bus_pkg::IDX_W+1:2]], idata);
				end
				i_pend = 1'b0;
			end else if (ivalid && !i_pend) begin
				i_pend  = 1'b1;
				i_start = cycle;
			end
			if (test_end) begin
				$display("Test %0d %s finished: %0d checks, %0d errors",
					test_id, test_name(test_id), test_checks, test_errs);
				test_checks = 0;
				test_errs   = 0;
			end
		end
	end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/10ps
// Testbench top that drives both core ports of the memory subsystem and runs the watchdog.
module tb_top;

	localparam int RESET_CYCLES = 10;
	localparam int N_TESTS      = 6;
	localparam int N_REQ        = 16 + 12 + 27 + 2 + 216; // Requests over all tests.
	localparam int WD_CYCLES    = N_REQ * 200 + RESET_CYCLES;

	logic                   clock;
	logic                   reset;
	logic                   ivalid;
	logic [31:0]            iaddr;
	logic                   iready;
	logic [31:0]            idata;
	logic                   dvalid;
	wb_bus_pkg::core_dreq_t dreq;
	logic                   dready;
	logic [31:0]            drdata;
	int                     test_id;
	logic                   test_end;
	int                     errors;
	int                     checks;
	logic [31:0]            rng;
	logic [31:0]            r;
	logic [31:0]            addr;

	logic [3:0]  stb_tab [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
	// Old words and operands for SWAP through MAXU.
	logic [31:0] amo_old [9] = '{32'h1234_5678, 32'hffff_fff0, 32'ha5a5_a5a5, 32'hf0f0_f0f0,
		32'h0101_0101, 32'hffff_fff6, 32'hffff_fff6, 32'hffff_fff6, 32'hffff_fff6};
	logic [31:0] amo_opd [9] = '{32'hdead_beef, 32'h0000_0020, 32'h0ff0_0ff0, 32'h3c3c_3c3c,
		32'h1000_0010, 32'h0000_0005, 32'h0000_0005, 32'h0000_0005, 32'h0000_0005};

	tb_clock_gen u_clk (.clock(clock), .reset(reset));

	wb_subsystem_top DUT (
		.clock  (clock),
		.reset  (reset),
		.ivalid (ivalid),
		.iaddr  (iaddr),
		.iready (iready),
		.idata  (idata),
		.dvalid (dvalid),
		.dreq   (dreq),
		.dready (dready),
		.drdata (drdata)
	);

	tb_checker u_chk (
		.clock    (clock),
		.reset    (reset),
		.ivalid   (ivalid),
		.iaddr    (iaddr),
		.iready   (iready),
		.idata    (idata),
		.dvalid   (dvalid),
		.dreq     (dreq),
		.dready   (dready),
		.drdata   (drdata),
		.test_id  (test_id),
		.test_end (test_end),
		.errors   (errors),
		.checks   (checks)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic data_req(input logic [31:0] a, input logic [31:0] wdata,
		input logic [3:0] wstb, input logic write, input wb_bus_pkg::amo_op_t amo);
		@(posedge clock);
		dvalid      <= 1'b1;
		dreq.addr   <= a;
		dreq.wdata  <= wdata;
		dreq.wstb   <= wstb;
		dreq.write  <= write;
		dreq.amo    <= amo;
		do @(posedge clock); while (!dready);
		dvalid <= 1'b0;
	endtask

	task automatic write_word(input logic [31:0] a, input logic [31:0] d);
		data_req(a, d, 4'hf, 1'b1, wb_bus_pkg::NONE);
	endtask

	task automatic read_word(input logic [31:0] a);
		data_req(a, 32'h0, 4'h0, 1'b0, wb_bus_pkg::NONE);
	endtask

	task automatic fetch_req(input logic [31:0] a);
		@(posedge clock);
		ivalid <= 1'b1;
		iaddr  <= a;
		do @(posedge clock); while (!iready);
		ivalid <= 1'b0;
	endtask

	// Data read and fetch presented in the same cycle.
	task automatic both_req(input logic [31:0] a_d, input logic [31:0] a_i);
		bit got_d;
		bit got_i;
		got_d = 1'b0;
		got_i = 1'b0;
		@(posedge clock);
		dvalid     <= 1'b1;
		dreq.addr  <= a_d;
		dreq.wdata <= 32'h0;
		dreq.wstb  <= 4'h0;
		dreq.write <= 1'b0;
		dreq.amo   <= wb_bus_pkg::NONE;
		ivalid     <= 1'b1;
		iaddr      <= a_i;
		while (!(got_d && got_i)) begin
			@(posedge clock);
			if (dready) begin
				dvalid <= 1'b0;
				got_d = 1'b1;
			end
			if (iready) begin
				ivalid <= 1'b0;
				got_i = 1'b1;
			end
		end
	endtask

	task automatic end_test();
		@(posedge clock);
		test_end <= 1'b1;
		@(posedge clock);
		test_end <= 1'b0;
		test_id  <= test_id + 1;
	endtask

	initial begin
		ivalid   = 1'b0;
		iaddr    = '0;
		dvalid   = 1'b0;
		dreq     = '0;
		test_id  = 0;
		test_end = 1'b0;
		rng      = 32'hfcde_5707;
		wait (reset == 1'b0);
		repeat (3) @(posedge clock); // Ports stay quiet after reset.
		end_test();
		for (int k = 0; k < 8; k++) begin
			write_word({22'd0, 8'(k), 2'b00}, 32'hc0de_0000 + 32'(k) * 32'h0001_0101);
		end
		for (int k = 0; k < 8; k++) begin
			fetch_req({22'd0, 8'(k), 2'b00});
		end
		end_test();
		for (int k = 0; k < 4; k++) begin
			write_word({22'd0, 8'(16 + k), 2'b00}, 32'h1122_3344);
		end
		for (int k = 0; k < 4; k++) begin
			data_req({22'd0, 8'(16 + k), 2'b00}, 32'haabb_ccdd, stb_tab[k], 1'b1,
				wb_bus_pkg::NONE);
		end
		for (int k = 0; k < 4; k++) begin
			read_word({22'd0, 8'(16 + k), 2'b00});
		end
		end_test();
		for (int k = 0; k < 9; k++) begin
			addr = {22'd0, 8'(32 + k), 2'b00};
			write_word(addr, amo_old[k]);
			data_req(addr, amo_opd[k], 4'hf, 1'b0, wb_bus_pkg::amo_op_t'(4'(k + 1)));
			read_word(addr);
		end
		end_test();
		both_req(32'h0000_0004, 32'h0000_0040);
		end_test();
		for (int k = 0; k < 16; k++) begin
			rng = xorshift(rng);
			write_word({22'd0, 8'(64 + k), 2'b00}, rng);
		end
		for (int n = 0; n < 200; n++) begin
			rng = xorshift(rng);
			r   = rng;
			rng = xorshift(rng);
			// Upper bits alias.
			addr = {r[6] ? rng[31:10] : 22'd0, 8'd64 + {4'd0, r[5:2]}, 2'b00};
			case (r[9:8])
				2'd0: fetch_req(addr);
				2'd1: read_word(addr);
				2'd2: data_req(addr, rng, (r[13:10] == 4'd0) ? 4'hf : r[13:10], 1'b1,
					wb_bus_pkg::NONE);
				default: data_req(addr, rng, 4'hf, 1'b0,
					wb_bus_pkg::amo_op_t'(4'd1 + r[17:14] % 4'd9));
			endcase
		end
		end_test();
		@(posedge clock);
		$display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles, a request never completed", WD_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== filelist.f ====
design/wb_bus_pkg.sv
design/sram_bank.sv
design/wb_amo_unit.sv
design/rv_bus_bridge.sv
design/wb_subsystem_top.sv
dv/tb_clock_gen.sv
dv/rv_bus_bridge_props.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = filelist.f
BUILD    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# The run fails unless the pass line appears in the output.
run: compile
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q -F '** PASS **'

clean:
	rm -rf $(BUILD)
